/* logic/dsp_pkg.sv */
package dsp_pkg;

    // Lanes per block and taps per lane
    localparam integer channel_width     = 4;
    localparam integer est_channel_depth = 6;

    // PAM4 symbol code
    // 0, 1, 2, 3 stand for the levels -3, -1, +1, +3
    typedef logic [1:0] symbol_t;

    // Measured ADC code
    typedef logic signed [7:0] code_t;

    // Channel response taps and per-lane shift
    typedef logic signed [9:0] tap_t;
    typedef logic        [3:0] shift_t;

    // Six full-scale tap products fit without loss before the shift
    typedef logic signed [15:0] est_code_t;

    // Estimate minus code, one extra bit
    typedef logic signed [16:0] error_t;

    function automatic logic signed [2:0] symbol_level(input symbol_t sym);
        logic signed [2:0] level;
        case (sym)
            2'd0:    level = -3'sd3;
            2'd1:    level = -3'sd1;
            2'd2:    level = 3'sd1;
            default: level = 3'sd3;
        endcase
        return level;
    endfunction

endpackage

/* logic/window_if.sv */
`timescale 1ns/1ps

interface window_if;
    import dsp_pkg::*;

    logic valid;

    // Oldest block in 0..3, middle block in 4..7, newest block in 8..11
    symbol_t window [3*channel_width-1:0];

    // Codes of the middle block
    code_t codes [channel_width-1:0];

    modport source (
        output valid,
        output window,
        output codes
    );

    modport sink (
        input valid,
        input window,
        input codes
    );

endinterface

/* logic/estimate_if.sv */
`timescale 1ns/1ps

interface estimate_if;
    import dsp_pkg::*;

    logic      valid;
    est_code_t est_code [channel_width-1:0];
    code_t     codes    [channel_width-1:0];

    // Symbols the estimates belong to
    symbol_t   symbols  [channel_width-1:0];

    modport source (
        output valid,
        output est_code,
        output codes,
        output symbols
    );

    modport sink (
        input valid,
        input est_code,
        input codes,
        input symbols
    );

endinterface

/* logic/symbol_history.sv */
`timescale 1ns/1ps

module symbol_history (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  dsp_pkg::symbol_t symbols [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::code_t   codes   [dsp_pkg::channel_width-1:0],
    window_if.source         win
);
    import dsp_pkg::*;

    localparam integer window_size = 3*channel_width;

    // Set once the first block after reset has been seen
    logic  has_prev;

    // Codes of the newest block, waiting for the next strobe
    code_t prev_codes [channel_width-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            has_prev  <= 1'b0;
            win.valid <= 1'b0;
        end else begin
            // Middle block only complete once a newer block arrives
            win.valid <= in_valid && has_prev;
            if (in_valid) begin
                has_prev <= 1'b1;
            end
        end
    end

    // Window shift by one block per strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < window_size; p++) begin
                win.window[p] <= '0;
            end
        end else if (in_valid) begin
            for (int p = 0; p < window_size - channel_width; p++) begin
                win.window[p] <= win.window[p + channel_width];
            end
            for (int i = 0; i < channel_width; i++) begin
                win.window[window_size - channel_width + i] <= symbols[i];
            end
        end
    end

    // Codes follow the middle block, one strobe behind the input
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < channel_width; i++) begin
                prev_codes[i] <= '0;
                win.codes[i]  <= '0;
            end
        end else if (in_valid) begin
            for (int i = 0; i < channel_width; i++) begin
                prev_codes[i] <= codes[i];
                win.codes[i]  <= prev_codes[i];
            end
        end
    end

    a_win_valid_after_strobe: assert property (
        @(posedge clk) disable iff (reset) win.valid |-> $past(in_valid)
    );

endmodule

/* logic/channel_filter.sv */
`timescale 1ns/1ps

module channel_filter #(
    parameter integer main_cursor_position = 2
) (
    input  logic             clk,
    input  logic             reset,
    window_if.sink           win,
    input  dsp_pkg::tap_t    channel_est   [dsp_pkg::channel_width-1:0]
                                           [dsp_pkg::est_channel_depth-1:0],
    input  dsp_pkg::shift_t  channel_shift [dsp_pkg::channel_width-1:0],
    estimate_if.source       est
);
    import dsp_pkg::*;

    // Window position of lane 0 in the middle block
    localparam integer mid_base = channel_width;

    // Oldest tap must still land inside the window
    localparam integer lowest_pos = mid_base + main_cursor_position - (est_channel_depth - 1);
    localparam integer highest_pos = mid_base + (channel_width - 1) + main_cursor_position;

    est_code_t filt_code [channel_width-1:0];

    initial begin
        assert (lowest_pos >= 0 && highest_pos < 3*channel_width)
            else $error("main_cursor_position %0d does not fit the window",
                        main_cursor_position);
    end

    // Tap k of lane i weighs the symbol k positions before the cursor
    // Taps below main_cursor_position are precursors from later symbols
    always_comb begin
        est_code_t acc;
        for (int i = 0; i < channel_width; i++) begin
            acc = '0;
            for (int k = 0; k < est_channel_depth; k++) begin
                acc = acc + channel_est[i][k]
                    * symbol_level(win.window[mid_base + i + main_cursor_position - k]);
            end
            // Arithmetic shift, rounds toward minus infinity
            filt_code[i] = acc >>> channel_shift[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            est.valid <= 1'b0;
        end else begin
            est.valid <= win.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win.valid) begin
            for (int i = 0; i < channel_width; i++) begin
                est.est_code[i] <= filt_code[i];
                est.codes[i]    <= win.codes[i];
                est.symbols[i]  <= win.window[mid_base + i];
            end
        end
    end

    a_est_follows_window: assert property (
        @(posedge clk) disable iff (reset) $rose(est.valid) |-> $past(win.valid)
    );

endmodule

/* logic/residual_error.sv */
`timescale 1ns/1ps

module residual_error (
    input  logic             clk,
    input  logic             reset,
    estimate_if.sink         est,
    output logic             out_valid,
    output dsp_pkg::error_t  res_err     [dsp_pkg::channel_width-1:0],
    output dsp_pkg::symbol_t symbols_out [dsp_pkg::channel_width-1:0]
);
    import dsp_pkg::*;

    error_t diff [channel_width-1:0];

    // Sign extended to the error width before the subtraction
    always_comb begin
        for (int i = 0; i < channel_width; i++) begin
            diff[i] = est.est_code[i] - est.codes[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= est.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (est.valid) begin
            for (int i = 0; i < channel_width; i++) begin
                res_err[i]     <= diff[i];
                symbols_out[i] <= est.symbols[i];
            end
        end
    end

    // Back-to-back outputs need back-to-back estimates
    a_out_pairs_from_est: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && $past(out_valid) |-> $past(est.valid) && $past(est.valid, 2)
    );

endmodule

/* logic/res_err_estimator.sv */
`timescale 1ns/1ps

module res_err_estimator #(
    parameter integer main_cursor_position = 2
) (
    input  logic             clk,
    input  logic             reset,

    // One block per strobe
    input  logic             in_valid,
    input  dsp_pkg::symbol_t symbols       [dsp_pkg::channel_width-1:0],
    input  dsp_pkg::code_t   codes         [dsp_pkg::channel_width-1:0],

    // Static channel response
    input  dsp_pkg::tap_t    channel_est   [dsp_pkg::channel_width-1:0]
                                           [dsp_pkg::est_channel_depth-1:0],
    input  dsp_pkg::shift_t  channel_shift [dsp_pkg::channel_width-1:0],

    // Results for the block before the latest strobe
    output logic             out_valid,
    output dsp_pkg::error_t  res_err       [dsp_pkg::channel_width-1:0],
    output dsp_pkg::symbol_t symbols_out   [dsp_pkg::channel_width-1:0]
);

    window_if   win_bus ();
    estimate_if est_bus ();

    symbol_history u_symbol_history (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .symbols  (symbols),
        .codes    (codes),
        .win      (win_bus.source)
    );

    // Estimates one cycle after the window
    channel_filter #(
        .main_cursor_position (main_cursor_position)
    ) u_channel_filter (
        .clk           (clk),
        .reset         (reset),
        .win           (win_bus.sink),
        .channel_est   (channel_est),
        .channel_shift (channel_shift),
        .est           (est_bus.source)
    );

    // Errors one cycle after the estimates
    residual_error u_residual_error (
        .clk         (clk),
        .reset       (reset),
        .est         (est_bus.sink),
        .out_valid   (out_valid),
        .res_err     (res_err),
        .symbols_out (symbols_out)
    );

endmodule

/* verif/res_err_estimator_tb.sv */
`timescale 1ns/1ps

module res_err_estimator_tb;
    import dsp_pkg::*;

    localparam integer out_timeout = 20;

    // Characters that open a line in the cases file
    localparam integer char_hash  = 35;
    localparam integer char_block = 98;
    localparam integer char_conf  = 99;

    logic    clk;
    logic    reset;
    logic    in_valid;
    symbol_t symbols       [channel_width-1:0];
    code_t   codes         [channel_width-1:0];
    tap_t    channel_est   [channel_width-1:0][est_channel_depth-1:0];
    shift_t  channel_shift [channel_width-1:0];
    logic    out_valid;
    error_t  res_err       [channel_width-1:0];
    symbol_t symbols_out   [channel_width-1:0];

    int cycle;
    int pulse_count;

    // Expected outputs, four entries per block in err_q and sym_q
    int due_q [$];
    int err_q [$];
    int sym_q [$];

    res_err_estimator #(
        .main_cursor_position (2)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .symbols       (symbols),
        .codes         (codes),
        .channel_est   (channel_est),
        .channel_shift (channel_shift),
        .out_valid     (out_valid),
        .res_err       (res_err),
        .symbols_out   (symbols_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_with(input string what);
        $display("%s at time %0t", what, $time);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // Outputs sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin : monitor
        int due;
        if (!reset) begin
            if (out_valid) begin
                assert (due_q.size() > 0) else begin
                    $display("out_valid pulsed with no block pending at time %0t", $time);
                    $display("TB FAILED");
                    $fatal(1, "unexpected pulse");
                end
                pulse_count = pulse_count + 1;
                due = due_q.pop_front();
                check_value("out_valid cycle", cycle, due);
                for (int i = 0; i < channel_width; i++) begin
                    check_value($sformatf("res_err[%0d]", i), int'(res_err[i]),
                                err_q.pop_front());
                    check_value($sformatf("symbols_out[%0d]", i), int'(symbols_out[i]),
                                sym_q.pop_front());
                end
            end else if (due_q.size() > 0) begin
                assert (due_q[0] > cycle) else begin
                    $display("out_valid missing in cycle %0d at time %0t", cycle, $time);
                    $display("TB FAILED");
                    $fatal(1, "missing pulse");
                end
            end
        end
    end

    task automatic read_int(input int fd, output int v);
        int n;
        n = $fscanf(fd, "%d", v);
        if (n != 1) begin
            stop_with("malformed line in cases file");
        end
    endtask

    task automatic apply_reset();
        reset    = 1'b1;
        in_valid = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // Drain the pending outputs and check the pulse count
    task automatic finish_section(input int blocks);
        int waited;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        waited = 0;
        while (due_q.size() > 0 && waited < out_timeout) begin
            @(posedge clk);
            waited++;
        end
        if (due_q.size() > 0) begin
            stop_with("timeout waiting for out_valid");
        end
        @(posedge clk);
        #1;
        check_value("pulse count", pulse_count, blocks - 1);
    endtask

    initial begin : driver
        int fd;
        int ch;
        int v;
        int gap;
        int blocks;
        int sections;
        int prev_sym [channel_width];
        int exp_err  [channel_width];
        logic [8*256-1:0] skip_buf;

        cycle       = 0;
        pulse_count = 0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        for (int i = 0; i < channel_width; i++) begin
            symbols[i]       = '0;
            codes[i]         = '0;
            channel_shift[i] = '0;
            for (int k = 0; k < est_channel_depth; k++) begin
                channel_est[i][k] = '0;
            end
        end

        fd = $fopen("verif/res_err_cases.txt", "r");
        if (fd == 0) begin
            stop_with("cannot open verif/res_err_cases.txt");
        end

        blocks   = 0;
        sections = 0;
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == char_hash) begin
                v = $fgets(skip_buf, fd);
            end else if (ch == char_conf) begin
                if (sections > 0) begin
                    finish_section(blocks);
                end
                for (int i = 0; i < channel_width; i++) begin
                    for (int k = 0; k < est_channel_depth; k++) begin
                        read_int(fd, v);
                        channel_est[i][k] = v[9:0];
                    end
                end
                for (int i = 0; i < channel_width; i++) begin
                    read_int(fd, v);
                    channel_shift[i] = v[3:0];
                end
                apply_reset();
                pulse_count = 0;
                blocks      = 0;
                sections++;
            end else if (ch == char_block) begin
                read_int(fd, gap);
                for (int g = 0; g < gap; g++) begin
                    @(posedge clk);
                    #1;
                    in_valid = 1'b0;
                end
                @(posedge clk);
                #1;
                in_valid = 1'b1;
                for (int i = 0; i < channel_width; i++) begin
                    read_int(fd, v);
                    symbols[i] = v[1:0];
                end
                for (int i = 0; i < channel_width; i++) begin
                    read_int(fd, v);
                    codes[i] = v[7:0];
                end
                for (int i = 0; i < channel_width; i++) begin
                    read_int(fd, exp_err[i]);
                end
                // Results of the previous block are due three edges later
                if (blocks > 0) begin
                    due_q.push_back(cycle + 3);
                    for (int i = 0; i < channel_width; i++) begin
                        err_q.push_back(exp_err[i]);
                        sym_q.push_back(prev_sym[i]);
                    end
                end
                for (int i = 0; i < channel_width; i++) begin
                    prev_sym[i] = int'(symbols[i]);
                end
                blocks++;
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);

        if (sections > 0) begin
            finish_section(blocks);
        end

        if (sections > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verif/res_err_cases.txt */
# c: 24 taps (lane 0 taps 0..5, then lanes 1..3), then 4 shifts
# b: idle gap, 4 symbols, 4 codes, 4 expected res_err of the previous block
# main_cursor_position is 2, tap 2 weighs the symbol itself
#
# Same taps on every lane, no shift
c
  1 -2 8 3 -1 2
  1 -2 8 3 -1 2
  1 -2 8 3 -1 2
  1 -2 8 3 -1 2
  0 0 0 0
# First block after reset, no output expected
b 0
  3 1 2 0
  10 -20 5 -7
  0 0 0 0
# Output for the first block, older block is reset history
b 5
  2 2 0 3
  0 3 -100 50
  5 13 -2 -8
# Back-to-back strobe
b 0
  0 3 1 1
  127 -128 1 2
  -9 22 63 -25
# Long gap
b 12
  1 0 3 2
  4 4 4 4
  -144 135 10 -23
#
# Lane taps differ, shifts 0 and 3 with floor rounding
c
  0 0 16 0 0 0
  -5 7 -40 9 -11 3
  2 0 -3 0 0 -1
  100 -50 -200 25 13 -7
  0 3 0 3
b 3
  1 3 0 2
  -1 2 -3 4
  0 0 0 0
b 0
  3 0 2 1
  20 -20 0 -128
  -15 -19 21 -89
b 0
  2 1 3 0
  0 0 0 0
  28 37 -2 129

/* tb.f */
logic/dsp_pkg.sv
logic/window_if.sv
logic/estimate_if.sv
logic/symbol_history.sv
logic/channel_filter.sv
logic/residual_error.sv
logic/res_err_estimator.sv
verif/res_err_estimator_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the res_err_estimator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module res_err_estimator_tb \
    -f tb.f \
    -o sim_res_err

sim_out=$(./obj_dir/sim_res_err 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "TB PASSED"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
